/* rtl/rangeCheckPkg.sv */
package rangeCheckPkg;

	// prefix structure codes, passed down as the speed parameter
	localparam int speedSerial    = 0;  // ripple chain, smallest
	localparam int speedBrentKung = 1;  // 2*log2 levels, sparse
	localparam int speedSklansky  = 2;  // log2 levels, high fanout

	// zone output codes
	localparam logic [1:0] zoneBelow  = 2'd0;
	localparam logic [1:0] zoneInside = 2'd1;
	localparam logic [1:0] zoneAbove  = 2'd2;

	// floor(log2(n)), gives -1 for n < 1
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

endpackage

/* rtl/prefixAndOr.sv */
`timescale 1ns/10ps

module prefixAndOr #(
	parameter int width = 8,  // word width
	parameter int speed = 1   // structure select, see package codes
) (
	input  logic [width-1:0] GI,  // generate in
	input  logic [width-1:0] PI,  // propagate in
	output logic [width-1:0] GO,  // prefix generate out
	output logic [width-1:0] PO   // prefix propagate out
);

	// levels needed to span the word
	localparam int depth = (width > 1) ? rangeCheckPkg::log2floor(width - 1) + 1 : 0;

	// each node: g = gHi | (pHi & gLo), p = pHi & pLo
	if (speed == rangeCheckPkg::speedSklansky) begin : sklansky
		logic [width-1:0] gT [0:depth];  // level results
		logic [width-1:0] pT [0:depth];

		always_comb begin
			gT[0] = GI;
			pT[0] = PI;
			for (int l = 1; l <= depth; l++) begin
				gT[l] = gT[l-1];  // default pass through
				pT[l] = pT[l-1];
				for (int i = 0; i < width; i++) begin
					// upper half of each 2^l block takes the lower half's last node
					if (((i >> (l - 1)) & 1) == 1) begin
						gT[l][i] = gT[l-1][i]
							| (pT[l-1][i] & gT[l-1][((i >> (l - 1)) << (l - 1)) - 1]);
						pT[l][i] = pT[l-1][i]
							& pT[l-1][((i >> (l - 1)) << (l - 1)) - 1];
					end
				end
			end
		end

		assign GO = gT[depth];
		assign PO = pT[depth];
	end else if (speed == rangeCheckPkg::speedBrentKung) begin : brentKung
		// up-sweep of depth levels, then depth-1 levels back down
		localparam int bkLevels = (depth > 0) ? 2 * depth - 1 : 0;

		logic [width-1:0] gT [0:bkLevels];
		logic [width-1:0] pT [0:bkLevels];

		always_comb begin
			gT[0] = GI;
			pT[0] = PI;
			// up-sweep, builds spans at the block tops
			for (int l = 1; l <= depth; l++) begin
				gT[l] = gT[l-1];
				pT[l] = pT[l-1];
				for (int i = 0; i < width; i++) begin
					if ((i + 1) % (1 << l) == 0) begin
						gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i - (1 << (l - 1))]);
						pT[l][i] = pT[l-1][i] & pT[l-1][i - (1 << (l - 1))];
					end
				end
			end
			// down-sweep, fills in the mid-block nodes
			for (int l = depth - 1; l >= 1; l--) begin
				gT[2*depth-l] = gT[2*depth-l-1];
				pT[2*depth-l] = pT[2*depth-l-1];
				for (int i = 0; i < width; i++) begin
					if (((i + 1) % (1 << l) == (1 << (l - 1))) && (i >= (1 << l))) begin
						gT[2*depth-l][i] = gT[2*depth-l-1][i]
							| (pT[2*depth-l-1][i] & gT[2*depth-l-1][i - (1 << (l - 1))]);
						pT[2*depth-l][i] = pT[2*depth-l-1][i]
							& pT[2*depth-l-1][i - (1 << (l - 1))];
					end
				end
			end
		end

		assign GO = gT[bkLevels];
		assign PO = pT[bkLevels];
	end else begin : serial
		logic [width-1:0] gT;  // ripple chain
		logic [width-1:0] pT;

		always_comb begin
			gT[0] = GI[0];
			pT[0] = PI[0];
			for (int i = 1; i < width; i++) begin
				gT[i] = GI[i] | (PI[i] & gT[i-1]);  // one node per bit
				pT[i] = PI[i] & pT[i-1];
			end
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

/* rtl/cmpEqGe.sv */
`timescale 1ns/10ps

module cmpEqGe #(
	parameter int width = 8,  // operand width
	parameter int speed = 1   // prefix structure
) (
	input  logic [width-1:0] A,   // operands, unsigned
	input  logic [width-1:0] B,
	output logic             EQ,  // A == B
	output logic             GE   // A >= B
);

	logic [width-1:0] GI;  // per-bit generate
	logic [width-1:0] PI;  // per-bit propagate
	logic [width-1:0] GO;
	logic [width-1:0] PO;

	// subtraction A - B reduced to carry terms
	always_comb begin
		PI = ~(A ^ B);  // bits equal, carry passes
		GI = A & ~B;    // A bit wins
		GI[0] = A[0] | ~B[0];  // carry-in of one folded into lsb
	end

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix_inst (
		.GI(GI),
		.PI(PI),
		.GO(GO),
		.PO(PO)
	);

	// msb carries the full-word result
	assign EQ = PO[width-1];  // all bits equal
	assign GE = GO[width-1];  // carry out, no borrow

endmodule

/* rtl/boundIf.sv */
`timescale 1ns/10ps

interface boundIf #(
	parameter int width = 8  // sample width
);

	logic             valid;   // one-cycle strobe per sample
	logic [width-1:0] data;    // registered sample
	logic             geLow;   // data >= lowBound
	logic             geHigh;  // data >= highBound
	logic             eqLow;   // data == lowBound
	logic             eqHigh;  // data == highBound

	// stage one side
	modport src (
		output valid,
		output data,
		output geLow,
		output geHigh,
		output eqLow,
		output eqHigh
	);

	// stage two side
	modport dst (
		input valid,
		input data,
		input geLow,
		input geHigh,
		input eqLow,
		input eqHigh
	);

endinterface

/* rtl/boundStage.sv */
`timescale 1ns/10ps

module boundStage #(
	parameter int width = 8,  // sample width
	parameter int speed = 1   // comparator structure
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [width-1:0] sample,
	input  logic             sampleValid,
	input  logic [width-1:0] lowBound,   // held level
	input  logic [width-1:0] highBound,  // held level
	boundIf.src              out
);

	logic eqLowComb;   // sample == lowBound
	logic geLowComb;   // sample >= lowBound
	logic eqHighComb;  // sample == highBound
	logic geHighComb;  // sample >= highBound

	// compare against low bound
	cmpEqGe #(
		.width(width),
		.speed(speed)
	) cmpLow_inst (
		.A(sample),
		.B(lowBound),
		.EQ(eqLowComb),
		.GE(geLowComb)
	);

	// compare against high bound
	cmpEqGe #(
		.width(width),
		.speed(speed)
	) cmpHigh_inst (
		.A(sample),
		.B(highBound),
		.EQ(eqHighComb),
		.GE(geHighComb)
	);

	// strobe, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= sampleValid;  // one cycle per accepted sample
		end
	end

	// payload and flags, only loaded on a valid sample
	always_ff @(posedge clk) begin
		if (sampleValid) begin
			out.data   <= sample;
			out.geLow  <= geLowComb;
			out.geHigh <= geHighComb;
			out.eqLow  <= eqLowComb;
			out.eqHigh <= eqHighComb;
		end
	end

	// an X sample would poison the flags and the running max downstream
	sampleKnown: assert property (
		@(posedge clk) disable iff (rst)
		sampleValid |-> !$isunknown(sample)
	) else $error("boundStage: unknown bits on sample while sampleValid is high");

endmodule

/* rtl/zoneStage.sv */
`timescale 1ns/10ps

module zoneStage #(
	parameter int width      = 8,  // sample width
	parameter int speed      = 1,  // comparator structure
	parameter int countWidth = 4   // excursion counter width
) (
	input  logic                  clk,
	input  logic                  rst,
	boundIf.dst                   in,
	output logic                  outValid,
	output logic [1:0]            zone,
	output logic                  atBound,
	output logic [width-1:0]      runMax,
	output logic [countWidth-1:0] excursionCount
);

	logic       geMax;     // incoming sample >= held max
	logic [1:0] zoneNext;  // decoded zone of incoming sample
	logic       outside;   // sample outside the window

	// new sample against running max
	cmpEqGe #(
		.width(width),
		.speed(speed)
	) cmpMax_inst (
		.A(in.data),
		.B(runMax),
		.EQ(),
		.GE(geMax)
	);

	// below wins over above, so inverted bounds still land somewhere
	always_comb begin
		if (!in.geLow) begin
			zoneNext = rangeCheckPkg::zoneBelow;  // sample < low
		end else if (in.geHigh && !in.eqHigh) begin
			zoneNext = rangeCheckPkg::zoneAbove;  // sample > high
		end else begin
			zoneNext = rangeCheckPkg::zoneInside;
		end
	end

	assign outside = (zoneNext != rangeCheckPkg::zoneInside);

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid       <= 1'b0;
			zone           <= '0;
			atBound        <= 1'b0;
			runMax         <= '0;
			excursionCount <= '0;
		end else begin
			outValid <= in.valid;  // fixed one-cycle delay
			if (in.valid) begin
				zone    <= zoneNext;
				atBound <= in.eqLow | in.eqHigh;
				if (geMax) begin
					runMax <= in.data;  // equal case reloads same value
				end
				// saturate at all ones
				if (outside && (excursionCount != {countWidth{1'b1}})) begin
					excursionCount <= excursionCount + countWidth'(1);
				end
			end
		end
	end

	// each stage-one strobe gives a result one cycle later, with known values
	validFollows: assert property (
		@(posedge clk) disable iff (rst)
		in.valid |=> (outValid && !$isunknown({zone, atBound, runMax, excursionCount}))
	) else $error("zoneStage: no known result one cycle after in.valid");

	// once full, counter holds until reset
	countNoWrap: assert property (
		@(posedge clk) disable iff (rst)
		(&excursionCount) |=> (&excursionCount)
	) else $error("zoneStage: excursionCount left saturation");

endmodule

/* rtl/rangeCheck.sv */
`timescale 1ns/10ps

module rangeCheck #(
	parameter int width      = 8,                             // sample width
	parameter int speed      = rangeCheckPkg::speedBrentKung, // prefix structure
	parameter int countWidth = 4                              // excursion counter
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [width-1:0]      sample,
	input  logic                  sampleValid,
	input  logic [width-1:0]      lowBound,
	input  logic [width-1:0]      highBound,
	output logic                  outValid,        // two cycles after sampleValid
	output logic [1:0]            zone,
	output logic                  atBound,
	output logic [width-1:0]      runMax,
	output logic [countWidth-1:0] excursionCount
);

	// stage one to stage two link
	boundIf #(
		.width(width)
	) link ();

	// compare with both bounds, register flags
	boundStage #(
		.width(width),
		.speed(speed)
	) boundStage_inst (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.sampleValid(sampleValid),
		.lowBound(lowBound),
		.highBound(highBound),
		.out(link.src)
	);

	// classify zone, track max and excursions
	zoneStage #(
		.width(width),
		.speed(speed),
		.countWidth(countWidth)
	) zoneStage_inst (
		.clk(clk),
		.rst(rst),
		.in(link.dst),
		.outValid(outValid),
		.zone(zone),
		.atBound(atBound),
		.runMax(runMax),
		.excursionCount(excursionCount)
	);

endmodule

/* dv/rangeCheckTb.sv */
`timescale 1ns/10ps

module rangeCheckTb;

	localparam int width      = 8;
	localparam int satLevel   = 15;  // excursion count ceiling
	localparam int countWidth = rangeCheckPkg::log2floor(satLevel) + 1;
	localparam int drainLimit = 10;  // cycles allowed for items in flight

	// one expected output record
	typedef struct packed {
		int                    due;  // step index where outputs show
		logic [1:0]            zone;
		logic                  atBound;
		logic [width-1:0]      runMax;
		logic [countWidth-1:0] count;
	} expEntry;

	logic                  clk;
	logic                  rst;
	logic [width-1:0]      sample;
	logic                  sampleValid;
	logic [width-1:0]      lowBound;
	logic [width-1:0]      highBound;
	logic                  outValid;
	logic [1:0]            zone;
	logic                  atBound;
	logic [width-1:0]      runMax;
	logic [countWidth-1:0] excursionCount;

	expEntry               modelQ[$];  // accepted samples still in flight
	int                    cycle;      // negedge counter
	int                    seedDummy;
	logic [width-1:0]      modelMax;
	logic [countWidth-1:0] modelCount;
	logic                  expValid;   // what the DUT shows right now
	logic [1:0]            expZone;
	logic                  expAtBound;
	logic [width-1:0]      expMax;
	logic [countWidth-1:0] expCount;
	logic                  expZeroState;  // outputs must read reset values

	rangeCheck #(
		.width(width),
		.speed(rangeCheckPkg::speedBrentKung),
		.countWidth(countWidth)
	) rangeCheck_inst (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.sampleValid(sampleValid),
		.lowBound(lowBound),
		.highBound(highBound),
		.outValid(outValid),
		.zone(zone),
		.atBound(atBound),
		.runMax(runMax),
		.excursionCount(excursionCount)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;  // 100 ns period

	task automatic failRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		failRun($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// move to the next falling edge and load the expected outputs
	task automatic nextStep();
		expEntry e;
		@(negedge clk);
		cycle = cycle + 1;
		expZeroState = rst;  // rst was held through the last rising edge
		expValid = 1'b0;
		if (modelQ.size() != 0 && modelQ[0].due == cycle) begin
			e = modelQ.pop_front();
			expValid   = 1'b1;
			expZone    = e.zone;
			expAtBound = e.atBound;
			expMax     = e.runMax;
			expCount   = e.count;
		end
	endtask

	// zone, bound, max and count rules for one accepted sample
	task automatic modelPush(input logic [width-1:0] s, input logic [width-1:0] lo,
			input logic [width-1:0] hi);
		expEntry e;
		e.due = cycle + 2;  // fixed two-cycle latency
		if (s < lo) begin
			e.zone = rangeCheckPkg::zoneBelow;
		end else if (s > hi) begin
			e.zone = rangeCheckPkg::zoneAbove;
		end else begin
			e.zone = rangeCheckPkg::zoneInside;
		end
		e.atBound = (s == lo) || (s == hi);
		if (s > modelMax) begin
			modelMax = s;
		end
		e.runMax = modelMax;  // includes this sample
		if (e.zone != rangeCheckPkg::zoneInside && modelCount != satLevel) begin
			modelCount = modelCount + 1'b1;
		end
		e.count = modelCount;
		modelQ.push_back(e);
	endtask

	task automatic driveSample(input logic v, input logic [width-1:0] s,
			input logic [width-1:0] lo, input logic [width-1:0] hi);
		nextStep();
		sampleValid = v;
		sample      = s;
		lowBound    = lo;
		highBound   = hi;
		if (v) begin
			modelPush(s, lo, hi);
		end
	endtask

	task automatic idle();
		driveSample(1'b0, sample, lowBound, highBound);
	endtask

	// three rising edges under reset, model state and in-flight items dropped
	task automatic applyReset();
		nextStep();
		rst = 1'b1;
		sampleValid = 1'b0;
		modelQ.delete();
		modelMax   = '0;
		modelCount = '0;
		repeat (3) nextStep();
		rst = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (modelQ.size() != 0 && n < drainLimit) begin
			idle();
			n = n + 1;
		end
		if (modelQ.size() != 0) begin
			failRun("timeout: outputs for accepted samples did not arrive");
		end
	endtask

	// samples on and next to each bound, back to back
	task automatic boundaryPair(input logic [width-1:0] lo, input logic [width-1:0] hi);
		driveSample(1'b1, lo, lo, hi);
		driveSample(1'b1, hi, lo, hi);
		driveSample(1'b1, lo - 1'b1, lo, hi);
		driveSample(1'b1, lo + 1'b1, lo, hi);
		driveSample(1'b1, hi - 1'b1, lo, hi);
		driveSample(1'b1, hi + 1'b1, lo, hi);
	endtask

	validCheck: assert property (@(posedge clk) disable iff (rst) outValid == expValid)
		else reportMismatch("outValid", $sampled(outValid), $sampled(expValid));
	zoneCheck: assert property (@(posedge clk) disable iff (rst) expValid |-> zone == expZone)
		else reportMismatch("zone", $sampled(zone), $sampled(expZone));
	atBoundCheck: assert property (
		@(posedge clk) disable iff (rst) expValid |-> atBound == expAtBound
	) else reportMismatch("atBound", $sampled(atBound), $sampled(expAtBound));
	maxCheck: assert property (@(posedge clk) disable iff (rst) expValid |-> runMax == expMax)
		else reportMismatch("runMax", $sampled(runMax), $sampled(expMax));
	countCheck: assert property (
		@(posedge clk) disable iff (rst) expValid |-> excursionCount == expCount
	) else reportMismatch("excursionCount", $sampled(excursionCount), $sampled(expCount));
	// reset values, during reset and on the first cycle out of it
	resetValidCheck: assert property (@(posedge clk) expZeroState |-> !outValid)
		else reportMismatch("outValid", $sampled(outValid), 0);
	resetMaxCheck: assert property (@(posedge clk) expZeroState |-> runMax == '0)
		else reportMismatch("runMax", $sampled(runMax), 0);
	resetCountCheck: assert property (@(posedge clk) expZeroState |-> excursionCount == '0)
		else reportMismatch("excursionCount", $sampled(excursionCount), 0);

	initial begin
		seedDummy    = $urandom(41413);
		rst          = 1'b1;
		sampleValid  = 1'b0;
		sample       = '0;
		lowBound     = '0;
		highBound    = '0;
		cycle        = 0;
		modelMax     = '0;
		modelCount   = '0;
		expValid     = 1'b0;
		expZone      = '0;
		expAtBound   = 1'b0;
		expMax       = '0;
		expCount     = '0;
		expZeroState = 1'b0;
		repeat (3) nextStep();
		rst = 1'b0;
		// random bounds, inverted ones included, random gaps
		repeat (300) begin
			driveSample($urandom_range(0, 3) != 0, $urandom_range(0, 255),
				$urandom_range(0, 255), $urandom_range(0, 255));
		end
		drain();
		boundaryPair(8'd40, 8'd200);
		boundaryPair(8'd100, 8'd100);  // equal bounds
		boundaryPair(8'd0, 8'd255);
		boundaryPair(8'd0, 8'd0);
		boundaryPair(8'd255, 8'd255);
		boundaryPair(8'd200, 8'd40);   // inverted
		drain();
		// burst cut off by reset mid-run
		repeat (4) driveSample(1'b1, $urandom_range(0, 255), 8'd50, 8'd60);
		applyReset();
		// running max from a cleared state
		driveSample(1'b1, 8'd30, 8'd0, 8'd255);
		driveSample(1'b1, 8'd30, 8'd0, 8'd255);  // equal to max
		idle();
		driveSample(1'b1, 8'd90, 8'd0, 8'd255);
		driveSample(1'b1, 8'd12, 8'd0, 8'd255);
		driveSample(1'b1, modelMax, 8'd0, 8'd255);
		driveSample(1'b1, 8'd255, 8'd0, 8'd255);
		driveSample(1'b1, 8'd255, 8'd0, 8'd255);
		driveSample(1'b1, 8'd7, 8'd0, 8'd255);
		drain();
		// excursions past saturation, inside samples mixed in
		for (int i = 0; i < 24; i++) begin
			driveSample(1'b1, $urandom_range(0, 99), 8'd100, 8'd150);
			driveSample(1'b1, $urandom_range(151, 255), 8'd100, 8'd150);
			if (i % 3 == 0) begin
				driveSample(1'b1, $urandom_range(100, 150), 8'd100, 8'd150);
			end
			if (i % 4 == 0) begin
				idle();
			end
		end
		drain();
		idle();
		idle();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* rangeCheck.f */
rtl/rangeCheckPkg.sv
rtl/prefixAndOr.sv
rtl/cmpEqGe.sv
rtl/boundIf.sv
rtl/boundStage.sv
rtl/zoneStage.sv
rtl/rangeCheck.sv
dv/rangeCheckTb.sv
